// File: banked_mem.f
source/mem_pkg.sv
source/mem_request_router.sv
source/mem_bank.sv
source/mem_response_merger.sv
source/banked_mem.sv
testbench/banked_mem_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the banked memory testbench with Verilator and run it.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
    --top-module banked_mem_tb \
    -f banked_mem.f \
    -o banked_mem_sim

# keep running after a failing simulation so the log decides the result
./obj_dir/banked_mem_sim 2>&1 | tee sim.log

if grep -qx "sim passed" sim.log; then
    echo "result: PASS"
else
    echo "result: FAIL"
    exit 1
fi

// File: testbench/banked_mem_tb.sv
`timescale 1ns/100ps
`default_nettype none

module banked_mem_tb
    import mem_pkg::*;
();

    localparam int ready_timeout = 50;
    localparam int drain_timeout = 100;
    localparam int random_count  = 200;

    logic      clk;
    logic      rst;
    logic      req_valid;
    mem_req_t  req;
    logic      req_ready;
    logic      resp_valid;
    mem_resp_t resp;

    int seed;
    int cycle = 0;

    // all four banks as one array indexed by word address
    logic [data_width-1:0] model [bank_count*bank_words];

    // outstanding responses in acceptance order
    mem_resp_t exp_resp_q [$];
    int        exp_cycle_q [$];
    string     exp_name_q [$];

    banked_mem UUT (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // index of the most recent rising edge
    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("[FAIL] %s expected %0h actual %0h", name, expected, actual));
        end
    endtask

    // expected response for a request and model update on an in-range write
    function automatic mem_resp_t expect_response(input mem_req_t r);
        mem_resp_t             e;
        logic [addr_width-1:0] a;
        int                    idx;
        a       = r.addr.flat;
        idx     = int'(a[byte_off_bits +: bank_word_bits + bank_index_bits]);
        e.addr  = a;
        e.error = (a[addr_width-1 -: upper_bits] != '0);
        e.rdata = '0;
        if (!e.error) begin
            e.rdata = model[idx];
            if (r.wen) begin
                model[idx] = r.wdata;
            end
        end
        return e;
    endfunction

    // hold the request until the handshake completes
    task automatic issue(input logic wen, input logic [addr_width-1:0] addr,
                         input logic [data_width-1:0] wdata, input string name,
                         output int accept_edge);
        int   waited;
        logic accepted;
        waited      = 0;
        accepted    = 1'b0;
        accept_edge = 0;
        @(negedge clk);
        req_valid     = 1'b1;
        req.addr.flat = addr;
        req.wen       = wen;
        req.wdata     = wdata;
        while (!accepted) begin
            @(posedge clk);
            if (req_ready) begin
                accepted    = 1'b1;
                accept_edge = cycle + 1;
                exp_resp_q.push_back(expect_response(req));
                exp_cycle_q.push_back(accept_edge);
                exp_name_q.push_back(name);
            end else if (waited == ready_timeout) begin
                abort_run($sformatf("timeout: request '%s' was never accepted", name));
            end else begin
                waited++;
            end
        end
    endtask

    task automatic go_idle();
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_resp_q.size() != 0) begin
            @(posedge clk);
            if (waited == drain_timeout) begin
                abort_run("timeout: responses still outstanding after the last request");
            end else begin
                waited++;
            end
        end
    endtask

    // registered outputs are settled at the falling edge
    always @(negedge clk) begin : compare_responses
        mem_resp_t exp_resp;
        int        exp_cycle;
        string     exp_name;
        if (resp_valid === 1'b1) begin
            if (exp_resp_q.size() == 0) begin
                abort_run($sformatf("response for address %h with no request pending",
                                    resp.addr));
            end else begin
                exp_resp  = exp_resp_q.pop_front();
                exp_cycle = exp_cycle_q.pop_front();
                exp_name  = exp_name_q.pop_front();
                check_value({exp_name, " addr"}, 64'(exp_resp.addr), 64'(resp.addr));
                check_value({exp_name, " error"}, 64'(exp_resp.error), 64'(resp.error));
                check_value({exp_name, " rdata"}, 64'(exp_resp.rdata), 64'(resp.rdata));
                check_value({exp_name, " arrival"}, 64'(exp_cycle + mem_latency),
                            64'(cycle));
            end
        end
    end

    initial begin
        int          e0;
        int          e1;
        int          e2;
        int          e3;
        logic [31:0] r;
        logic [31:0] addr;
        logic [31:0] data;
        seed       = 65;
        rst        = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        for (int i = 0; i < bank_count * bank_words; i++) begin
            model[i] = '0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // idle after reset with any address ready
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            req.addr.flat = $random(seed);
            @(posedge clk);
            check_value("idle req_ready", 64'(1), 64'(req_ready));
            check_value("idle resp_valid", 64'(0), 64'(resp_valid));
        end

        // same word index in every bank back to back
        issue(1'b1, 32'h0000_0100, 32'h1111_1111, "write bank 0", e0);
        issue(1'b1, 32'h0000_0104, 32'h2222_2222, "write bank 1", e1);
        issue(1'b1, 32'h0000_0108, 32'h3333_3333, "write bank 2", e2);
        issue(1'b1, 32'h0000_010c, 32'h4444_4444, "write bank 3", e3);
        check_value("write bank 1 edge", 64'(e0 + 1), 64'(e1));
        check_value("write bank 2 edge", 64'(e1 + 1), 64'(e2));
        check_value("write bank 3 edge", 64'(e2 + 1), 64'(e3));
        issue(1'b0, 32'h0000_0100, 32'h0, "read bank 0", e0);
        issue(1'b0, 32'h0000_0104, 32'h0, "read bank 1", e1);
        issue(1'b0, 32'h0000_0108, 32'h0, "read bank 2", e2);
        issue(1'b0, 32'h0000_010c, 32'h0, "read bank 3", e3);
        check_value("read bank 3 edge", 64'(e0 + 3), 64'(e3));
        issue(1'b1, 32'h0000_0100, 32'h5555_5555, "overwrite bank 0", e0);

        // out of range leaves memory alone
        issue(1'b1, 32'h0001_0104, 32'hdead_beef, "error write", e0);
        issue(1'b0, 32'hffff_f10c, 32'h0, "error read", e1);
        issue(1'b0, 32'h0000_0104, 32'h0, "read after error", e2);
        go_idle();
        wait_drain();

        // second access to one bank waits out the delay
        issue(1'b0, 32'h0000_0200, 32'h0, "busy first", e0);
        issue(1'b1, 32'h0000_0210, 32'h6666_6666, "busy second", e1);
        check_value("busy second edge", 64'(e0 + bank_delay), 64'(e1));
        issue(1'b1, 32'h0000_0220, 32'h7777_7777, "busy third", e2);
        issue(1'b0, 32'h1000_0220, 32'h0, "error while busy", e3);
        check_value("error while busy edge", 64'(e2 + 1), 64'(e3));
        go_idle();
        wait_drain();

        // random mix over a small window so words get reused
        for (int i = 0; i < random_count; i++) begin
            r    = $random(seed);
            data = $random(seed);
            addr = {24'h0, r[5:0], r[7:6]};
            if (r[11:8] == 4'h0) begin
                addr[31:12] = {r[31:13], 1'b1};
            end
            issue(r[12], addr, data, $sformatf("random %0d", i), e0);
        end
        go_idle();
        wait_drain();

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: source/banked_mem.sv
`timescale 1ns/100ps
`default_nettype none

module banked_mem
    import mem_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  logic      req_valid,
    input  mem_req_t  req,
    output logic      req_ready,

    output logic      resp_valid,
    output mem_resp_t resp
);

    logic [bank_count-1:0] bank_valid;
    logic [bank_count-1:0] bank_ready;
    mem_req_t              bank_req;

    logic [bank_count-1:0] bank_resp_valid;
    mem_resp_t             bank_resp [bank_count];

    logic                  err_valid;
    mem_resp_t             err_resp;

    mem_request_router u_router (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .bank_ready (bank_ready),
        .bank_valid (bank_valid),
        .bank_req   (bank_req),
        .err_valid  (err_valid),
        .err_resp   (err_resp)
    );

    // one bank per value of the bank field
    for (genvar i = 0; i < bank_count; i++) begin : g_bank
        mem_bank u_bank (
            .clk        (clk),
            .rst        (rst),
            .req_valid  (bank_valid[i]),
            .req        (bank_req),
            .ready      (bank_ready[i]),
            .resp_valid (bank_resp_valid[i]),
            .resp       (bank_resp[i])
        );
    end

    mem_response_merger u_merger (
        .clk             (clk),
        .rst             (rst),
        .bank_resp_valid (bank_resp_valid),
        .bank_resp       (bank_resp),
        .err_valid       (err_valid),
        .err_resp        (err_resp),
        .resp_valid      (resp_valid),
        .resp            (resp)
    );

endmodule

`default_nettype wire

// File: source/mem_response_merger.sv
`timescale 1ns/100ps
`default_nettype none

module mem_response_merger
    import mem_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,

    input  logic [bank_count-1:0] bank_resp_valid,
    input  mem_resp_t             bank_resp [bank_count],

    input  logic                  err_valid,
    input  mem_resp_t             err_resp,

    output logic                  resp_valid,
    output mem_resp_t             resp
);

    localparam int resp_bits = $bits(mem_resp_t);

    logic                 any_valid;
    logic [resp_bits-1:0] sel_bits;

    // and-or mux, at most one source is valid per cycle
    always_comb begin
        sel_bits = {resp_bits{err_valid}} & err_resp;
        for (int i = 0; i < bank_count; i++) begin
            sel_bits = sel_bits | ({resp_bits{bank_resp_valid[i]}} & bank_resp[i]);
        end
    end

    assign any_valid = err_valid || (|bank_resp_valid);

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= any_valid;
        end
    end

    // payload only moves with a strobe
    always_ff @(posedge clk) begin
        if (any_valid) begin
            resp <= mem_resp_t'(sel_bits);
        end
    end

endmodule

`default_nettype wire

// File: source/mem_bank.sv
`timescale 1ns/100ps
`default_nettype none

module mem_bank
    import mem_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  logic      req_valid,
    input  mem_req_t  req,
    output logic      ready,

    output logic      resp_valid,
    output mem_resp_t resp
);

    typedef enum logic {
        s_idle,
        s_delay
    } bank_state_t;

    localparam logic [delay_count_bits-1:0] last_count = delay_count_bits'(bank_delay - 1);

    logic [data_width-1:0]       mem [bank_words];

    bank_state_t                 state;
    logic [delay_count_bits-1:0] count;
    logic                        accept;
    logic                        done;

    // response captured at acceptance, held until the delay ends
    mem_resp_t                   held;

    // banks come up cleared
    initial begin
        for (int i = 0; i < bank_words; i++) begin
            mem[i] = '0;
        end
    end

    assign done = (state == s_delay) && (count == last_count);

    // free again in the last delay cycle, so a new access overlaps the response
    assign ready  = (state == s_idle) || done;
    assign accept = req_valid && ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= s_idle;
            count      <= '0;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            case (state)
                s_idle: begin
                    if (accept) begin
                        state <= s_delay;
                        count <= '0;
                    end
                end
                s_delay: begin
                    if (done) begin
                        resp_valid <= 1'b1;
                        if (accept) begin
                            count <= '0;
                        end else begin
                            state <= s_idle;
                        end
                    end else begin
                        count <= count + 1'b1;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    // old word is read before the write lands
    always_ff @(posedge clk) begin
        if (accept) begin
            held <= '{
                addr:  req.addr.flat,
                error: 1'b0,
                rdata: mem[req.addr.field.word]
            };
            if (req.wen) begin
                mem[req.addr.field.word] <= req.wdata;
            end
        end
        if (done) begin
            resp <= held;
        end
    end

endmodule

`default_nettype wire

// File: source/mem_request_router.sv
`timescale 1ns/100ps
`default_nettype none

module mem_request_router
    import mem_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  req_valid,
    input  mem_req_t              req,
    output logic                  req_ready,

    input  logic [bank_count-1:0] bank_ready,
    output logic [bank_count-1:0] bank_valid,
    output mem_req_t              bank_req,

    output logic                  err_valid,
    output mem_resp_t             err_resp
);

    logic                  in_range;
    logic                  target_ready;
    logic                  bank_accept;
    logic                  err_accept;

    // error path, one entry per bank delay cycle
    logic [bank_delay-1:0] err_pipe_valid;
    logic [addr_width-1:0] err_pipe_addr [bank_delay];

    // only the low bits may be set for a valid address
    assign in_range     = (req.addr.field.upper == '0);
    assign target_ready = bank_ready[req.addr.field.bank];

    // out of range requests are always taken
    assign req_ready = !in_range || target_ready;

    assign bank_accept = req_valid && in_range && target_ready;
    assign err_accept  = req_valid && !in_range;

    // one-hot strobe to the addressed bank
    always_comb begin
        bank_valid = '0;
        bank_valid[req.addr.field.bank] = bank_accept;
    end

    // all banks see the same request word
    assign bank_req = req;

    always_ff @(posedge clk) begin
        if (rst) begin
            err_pipe_valid <= '0;
            err_valid      <= 1'b0;
        end else begin
            err_pipe_valid <= {err_pipe_valid[bank_delay-2:0], err_accept};
            err_valid      <= err_pipe_valid[bank_delay-1];
        end
    end

    // address follows the valid bit down the pipe
    always_ff @(posedge clk) begin
        err_pipe_addr[0] <= req.addr.flat;
        for (int i = 1; i < bank_delay; i++) begin
            err_pipe_addr[i] <= err_pipe_addr[i-1];
        end
        err_resp <= '{
            addr:  err_pipe_addr[bank_delay-1],
            error: 1'b1,
            rdata: '0
        };
    end

endmodule

`default_nettype wire

// File: source/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // widths of the request port
    localparam int addr_width = 32;
    localparam int data_width = 32;

    // word interleaving over the banks
    localparam int bank_index_bits = 2;
    localparam int bank_count      = 2 ** bank_index_bits;
    localparam int bank_word_bits  = 8;
    localparam int bank_words      = 2 ** bank_word_bits;
    localparam int byte_off_bits   = 2;
    localparam int upper_bits      = addr_width - bank_word_bits
                                     - bank_index_bits - byte_off_bits;

    // access delay inside a bank, in cycles
    localparam int bank_delay       = 3;
    localparam int delay_count_bits = $clog2(bank_delay);

    // the merger adds one register behind the banks
    localparam int mem_latency = bank_delay + 1;

    // field view of a byte address
    typedef struct packed {
        logic [upper_bits-1:0]      upper;
        logic [bank_word_bits-1:0]  word;
        logic [bank_index_bits-1:0] bank;
        logic [byte_off_bits-1:0]   byte_off;
    } mem_addr_fields_t;

    // same address word, flat or split into fields
    typedef union packed {
        logic [addr_width-1:0] flat;
        mem_addr_fields_t      field;
    } mem_addr_u;

    typedef struct packed {
        mem_addr_u             addr;
        logic                  wen;
        logic [data_width-1:0] wdata;
    } mem_req_t;

    // rdata is zero whenever error is set
    typedef struct packed {
        logic [addr_width-1:0] addr;
        logic                  error;
        logic [data_width-1:0] rdata;
    } mem_resp_t;

endpackage

`default_nettype wire
